/* sfp_ctrl_pkg.sv */
// shared timing constants and link/host structs, imported by every sfp control module

package sfp_ctrl_pkg;

    // ------------------------------
    // counter widths
    // ------------------------------

    localparam int unsigned TIMER_W = 32;   // send counters and host timer

    // ------------------------------
    // channel 1 periodic scheduler
    // ------------------------------

    // pulse start count, board clock at 50 MHz
    localparam logic [TIMER_W-1:0] SEND_1_PERIOD_FULL = 32'h01312d00;

    // short period for simulation runs
    localparam logic [TIMER_W-1:0] SEND_1_PERIOD_FAST = 32'd255;

    // pulse stays high this many counts past the period
    localparam logic [TIMER_W-1:0] SEND_1_PULSE_LEN   = 32'd3;

    // counter wraps to zero this far past the period
    localparam logic [TIMER_W-1:0] SEND_1_RESTART_OFS = 32'd10;

    // ------------------------------
    // channel 2 host-timed scheduler
    // ------------------------------

    // extra counts on top of the host timer before the level drops
    localparam logic [TIMER_W-1:0] SEND_2_HOLD_OFS = 32'd3;

    // ------------------------------
    // health blink
    // ------------------------------

    localparam logic [TIMER_W-1:0] BLINK_HALF_FULL = 32'd25_000_000;  // 0.5 s at 50 MHz
    localparam logic [TIMER_W-1:0] BLINK_HALF_FAST = 32'd25;          // sim profile

    // ------------------------------
    // status and command bundles
    // ------------------------------

    // link state reported by the MAC and the receive transceiver
    typedef struct packed {
        logic mac_inited;        // MAC config done
        logic rx_ready;          // rx reset sequence finished
        logic rx_locked_to_ref;  // cdr locked to reference clock
    } link_status_t;

    // send control written by the host over PCIe
    typedef struct packed {
        logic               send_cmd;   // hold both channels in command mode
        logic [TIMER_W-1:0] ch2_timer;  // channel 2 on-time base
    } host_cmd_t;

endpackage

/* blink_divider.sv */
// health blinker, toggles blink_led every half_period clocks to show the pll clock is alive

`timescale 1ns/1ps

module blink_divider #(
    parameter logic [sfp_ctrl_pkg::TIMER_W-1:0] half_period = sfp_ctrl_pkg::BLINK_HALF_FULL
) (
    input  logic clk_50_pll,
    input  logic main_reset,
    output logic blink_led
);

    import sfp_ctrl_pkg::*;

    logic [TIMER_W-1:0] div_cnt;

    // wrap at half_period - 1 so each level lasts exactly half_period cycles
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            div_cnt   <= '0;
            blink_led <= 1'b0;
        end
        else
        begin
            if (div_cnt == half_period - 1'b1)
            begin
                div_cnt   <= '0;
                blink_led <= ~blink_led;   // flip the led
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

/* periodic_send_channel.sv */
// channel 1 scheduler, raises a three-cycle send pulse once per period while commanded

`timescale 1ns/1ps

module periodic_send_channel #(
    parameter logic [sfp_ctrl_pkg::TIMER_W-1:0] period = sfp_ctrl_pkg::SEND_1_PERIOD_FULL
) (
    input  logic clk_50_pll,
    input  logic main_reset,
    input  logic enable,      // link up, else freeze
    input  logic send_cmd,    // registered host command
    output logic cmd_send
);

    import sfp_ctrl_pkg::*;

    // ------------------------------
    // compare points
    // ------------------------------

    logic [TIMER_W-1:0] send_cnt;
    logic [TIMER_W-1:0] pulse_end;
    logic [TIMER_W-1:0] restart_at;

    assign pulse_end  = period + SEND_1_PULSE_LEN;     // drop the pulse here
    assign restart_at = period + SEND_1_RESTART_OFS;   // one full cycle is period + 11 clocks

    // ------------------------------
    // counter and pulse
    // ------------------------------

    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            send_cnt <= '0;
            cmd_send <= 1'b0;
        end
        else if (enable)
        begin
            if (send_cmd)
            begin
                send_cnt <= send_cnt + 1'b1;
                if (send_cnt == period)
                begin
                    cmd_send <= 1'b1;   // pulse starts next cycle
                end
                else if (send_cnt == pulse_end)
                begin
                    cmd_send <= 1'b0;
                end
                else if (send_cnt == restart_at)
                begin
                    send_cnt <= '0;     // overrides the increment
                end
            end
            else
            begin
                // counter keeps its value so a short command drop resumes the cycle
                cmd_send <= 1'b0;
            end
        end
    end

endmodule

/* host_send_channel.sv */
// channel 2 scheduler, host-timed send level in command mode, else follows the rx data-saved flag

`timescale 1ns/1ps

module host_send_channel (
    input  logic                         clk_50_pll,
    input  logic                         main_reset,
    input  logic                         enable,      // link up, else freeze
    input  logic                         send_cmd,    // registered host command
    input  logic [sfp_ctrl_pkg::TIMER_W-1:0] ch2_timer,   // registered on-time base
    input  logic                         data_saved,  // rx channel 2 has a frame stored
    output logic                         cmd_send
);

    import sfp_ctrl_pkg::*;

    logic [TIMER_W-1:0] hold_cnt;
    logic [TIMER_W-1:0] hold_limit;
    logic               hold_done;

    // ------------------------------
    // on-time compare
    // ------------------------------

    assign hold_limit = ch2_timer + SEND_2_HOLD_OFS;

    // greater-or-equal so a timer lowered mid-burst still ends the high phase
    assign hold_done  = (hold_cnt >= hold_limit);

    // ------------------------------
    // send level
    // ------------------------------

    // high for ch2_timer + 4 clocks, then one low clock, repeat
    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            hold_cnt <= '0;
            cmd_send <= 1'b0;
        end
        else if (enable)
        begin
            if (send_cmd)
            begin
                if (cmd_send)
                begin
                    if (hold_done)
                    begin
                        cmd_send <= 1'b0;   // the single low gap
                        hold_cnt <= '0;
                    end
                    else
                    begin
                        hold_cnt <= hold_cnt + 1'b1;
                    end
                end
                else
                begin
                    cmd_send <= 1'b1;       // restart right after the gap
                end
            end
            else
            begin
                // no command, mirror the receiver one clock late
                hold_cnt <= '0;
                cmd_send <= data_saved;
            end
        end
    end

endmodule

/* send_control.sv */
// send control, registers the host command, gates on link readiness and runs both schedulers

`timescale 1ns/1ps

module send_control #(
    parameter logic [sfp_ctrl_pkg::TIMER_W-1:0] send_1_period = sfp_ctrl_pkg::SEND_1_PERIOD_FULL
) (
    input  logic                       clk_50_pll,
    input  logic                       main_reset,
    input  sfp_ctrl_pkg::link_status_t link,
    input  sfp_ctrl_pkg::host_cmd_t    host,
    input  logic                       data_saved_2,
    output logic                       cmd_send_1,
    output logic                       cmd_send_2
);

    import sfp_ctrl_pkg::*;

    host_cmd_t host_q;   // host command one clock late
    logic      enable;

    // ------------------------------
    // host register
    // ------------------------------

    always_ff @(posedge clk_50_pll or posedge main_reset)
    begin
        if (main_reset)
        begin
            host_q <= '0;
        end
        else
        begin
            host_q <= host;
        end
    end

    // schedulers only run with mac configured and rx out of reset
    assign enable = link.mac_inited & link.rx_ready;

    // ------------------------------
    // channel schedulers
    // ------------------------------

    periodic_send_channel #(
        .period     (send_1_period)
    ) periodic_send_channel_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .enable     (enable),
        .send_cmd   (host_q.send_cmd),
        .cmd_send   (cmd_send_1)
    );

    host_send_channel host_send_channel_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset),
        .enable     (enable),
        .send_cmd   (host_q.send_cmd),
        .ch2_timer  (host_q.ch2_timer),
        .data_saved (data_saved_2),
        .cmd_send   (cmd_send_2)
    );

endmodule

/* sfp_ctrl_top.sv */
// board top for sfp send scheduling, picks the timing profile and drives the status leds

`timescale 1ns/1ps

module sfp_ctrl_top #(
    parameter bit fast_timing = 1'b0   // 1 selects the short sim constants
) (
    input  logic                       clk_50_pll,
    input  logic                       main_reset,
    input  sfp_ctrl_pkg::link_status_t link,
    input  sfp_ctrl_pkg::host_cmd_t    host,
    input  logic                       data_saved_2,

    output logic                       cmd_send_1,
    output logic                       cmd_send_2,

    output logic                       sfp_txflt_led,
    output logic                       sfp_rlos_led,
    output logic                       sfp_prsn_led,
    output logic                       blink_led
);

    import sfp_ctrl_pkg::*;

    // ------------------------------
    // health blink
    // ------------------------------

    blink_divider #(
        .half_period (fast_timing ? BLINK_HALF_FAST : BLINK_HALF_FULL)
    ) blink_divider_i (
        .clk_50_pll  (clk_50_pll),
        .main_reset  (main_reset),
        .blink_led   (blink_led)
    );

    // ------------------------------
    // send scheduling
    // ------------------------------

    send_control #(
        .send_1_period (fast_timing ? SEND_1_PERIOD_FAST : SEND_1_PERIOD_FULL)
    ) send_control_i (
        .clk_50_pll    (clk_50_pll),
        .main_reset    (main_reset),
        .link          (link),
        .host          (host),
        .data_saved_2  (data_saved_2),
        .cmd_send_1    (cmd_send_1),
        .cmd_send_2    (cmd_send_2)
    );

    // ------------------------------
    // status leds
    // ------------------------------

    // straight from the link flags, no registering
    assign sfp_txflt_led = link.mac_inited;
    assign sfp_rlos_led  = link.rx_ready;
    assign sfp_prsn_led  = link.rx_locked_to_ref;   // cdr lock to ref

endmodule

/* tb_clock_gen.sv */
// testbench clock and reset source, 100 ns clk_50_pll and a 5-cycle main_reset after time zero

`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_50_pll,
    output logic main_reset
);

    // 100 ns period, first rising edge at 50 ns
    initial
    begin
        clk_50_pll = 1'b0;
        forever #50 clk_50_pll = ~clk_50_pll;
    end

    // held over five rising edges, released on a falling edge
    initial
    begin
        main_reset = 1'b1;
        repeat (5) @(posedge clk_50_pll);
        @(negedge clk_50_pll);
        main_reset = 1'b0;
    end

endmodule

/* sfp_ctrl_tb.sv */
// directed testbench for sfp_ctrl_top in the fast profile and used as the simulation top

`timescale 1ns/1ps

module sfp_ctrl_tb;

    import sfp_ctrl_pkg::*;

    localparam int SEL_SEND_1   = 0;
    localparam int SEL_SEND_2   = 1;
    localparam int SEL_BLINK    = 2;
    localparam int BLINK_HALF   = 25;    // fast profile half-period
    localparam int SEND_1_WIDTH = 3;
    localparam int SEND_1_CYCLE = 266;   // rise to rise in the fast profile

    logic         clk_50_pll;
    logic         main_reset;
    link_status_t link;
    host_cmd_t    host;
    logic         data_saved_2;
    logic         cmd_send_1;
    logic         cmd_send_2;
    logic         sfp_txflt_led;
    logic         sfp_rlos_led;
    logic         sfp_prsn_led;
    logic         blink_led;

    int     checks = 0;
    int     errors = 0;
    integer seed   = 32'h7ee6;

    tb_clock_gen clock_gen_i (
        .clk_50_pll (clk_50_pll),
        .main_reset (main_reset)
    );

    sfp_ctrl_top #(
        .fast_timing   (1'b1)
    ) sfp_ctrl_top_i (
        .clk_50_pll    (clk_50_pll),
        .main_reset    (main_reset),
        .link          (link),
        .host          (host),
        .data_saved_2  (data_saved_2),
        .cmd_send_1    (cmd_send_1),
        .cmd_send_2    (cmd_send_2),
        .sfp_txflt_led (sfp_txflt_led),
        .sfp_rlos_led  (sfp_rlos_led),
        .sfp_prsn_led  (sfp_prsn_led),
        .blink_led     (blink_led)
    );

    // ------------------------------
    // helpers
    // ------------------------------

    // advance to 10 ns past the next rising edge where outputs are read and inputs change
    task step_cycle;
        @(posedge clk_50_pll);
        #10;
    endtask

    task check_equal(input logic [31:0] actual, input logic [31:0] expected, input string msg);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("MISMATCH at %0t ns: %s (got %0d, expected %0d)",
                     $time, msg, actual, expected);
        end
    endtask

    task set_link(input logic mac_inited, input logic rx_ready, input logic locked);
        link.mac_inited       = mac_inited;
        link.rx_ready         = rx_ready;
        link.rx_locked_to_ref = locked;
    endtask

    function automatic logic output_bit(input int sel);
        case (sel)
            SEL_SEND_1: return cmd_send_1;
            SEL_SEND_2: return cmd_send_2;
            default:    return blink_led;
        endcase
    endfunction

    function automatic string output_name(input int sel);
        case (sel)
            SEL_SEND_1: return "cmd_send_1";
            SEL_SEND_2: return "cmd_send_2";
            default:    return "blink_led";
        endcase
    endfunction

    // counts cycles until the chosen output reaches level or the limit runs out
    task automatic wait_level(input int sel, input logic level, input int limit,
                              output int cycles, output bit ok);
        cycles = 0;
        ok     = 1'b1;
        while (output_bit(sel) !== level && cycles < limit)
        begin
            step_cycle;
            cycles++;
        end
        if (output_bit(sel) !== level)
        begin
            ok = 1'b0;
            errors++;
            $display("timeout at %0t ns: %s did not reach %0b within %0d cycles",
                     $time, output_name(sel), level, limit);
        end
    endtask

    task report_test(input string name, input int start_errors);
        $display("test %s finished, %0d errors", name, errors - start_errors);
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task run_reset_test;
        int           n;
        int           i;
        int           start_errors;
        link_status_t combo;
        start_errors = errors;
        n = 0;
        while (main_reset !== 1'b0 && n < 20)
        begin
            step_cycle;
            n++;
        end
        if (main_reset !== 1'b0)
        begin
            errors++;
            $display("timeout: main_reset was still high after 20 cycles");
        end
        check_equal(cmd_send_1, 1'b0, "cmd_send_1 after reset");
        check_equal(cmd_send_2, 1'b0, "cmd_send_2 after reset");
        check_equal(blink_led, 1'b0, "blink_led after reset");
        for (i = 0; i < 8; i++)
        begin
            combo = i[2:0];
            link  = combo;
            #1;   // leds are combinational
            check_equal(sfp_txflt_led, combo.mac_inited, "sfp_txflt_led vs mac_inited");
            check_equal(sfp_rlos_led, combo.rx_ready, "sfp_rlos_led vs rx_ready");
            check_equal(sfp_prsn_led, combo.rx_locked_to_ref, "sfp_prsn_led vs rx_locked");
            step_cycle;
        end
        report_test("reset_and_leds", start_errors);
    endtask

    task run_blink_test;
        int n;
        int i;
        int start_errors;
        bit ok;
        start_errors = errors;
        wait_level(SEL_BLINK, ~blink_led, 2 * BLINK_HALF + 5, n, ok);   // sync to a toggle
        for (i = 0; i < 3 && ok; i++)
        begin
            wait_level(SEL_BLINK, ~blink_led, 2 * BLINK_HALF + 5, n, ok);
            if (ok)
            begin
                check_equal(n, BLINK_HALF, "cycles between blink_led toggles");
            end
        end
        report_test("blink", start_errors);
    endtask

    task run_periodic_test;
        int i;
        int high_len;
        int gap;
        int n_high;
        int start_errors;
        bit ok;
        start_errors = errors;
        set_link(1'b1, 1'b1, 1'b1);
        data_saved_2  = 1'b0;
        host.send_cmd = 1'b1;
        wait_level(SEL_SEND_1, 1'b1, SEND_1_CYCLE + 20, gap, ok);
        for (i = 0; i < 3 && ok; i++)
        begin
            wait_level(SEL_SEND_1, 1'b0, 10, high_len, ok);
            if (ok)
            begin
                check_equal(high_len, SEND_1_WIDTH, "cmd_send_1 pulse width");
                wait_level(SEL_SEND_1, 1'b1, SEND_1_CYCLE + 20, gap, ok);
            end
            if (ok)
            begin
                check_equal(high_len + gap, SEND_1_CYCLE, "cmd_send_1 rise to rise");
            end
        end
        host.send_cmd = 1'b0;
        repeat (2) step_cycle;   // host register and then the channel clear
        n_high = 0;
        for (i = 0; i < 300; i++)
        begin
            step_cycle;
            if (cmd_send_1 !== 1'b0)
            begin
                n_high++;
            end
        end
        check_equal(n_high, 0, "cmd_send_1 high cycles after send_cmd dropped");
        report_test("periodic_channel", start_errors);
    endtask

    task run_host_timed_test;
        int i;
        int k;
        int timer;
        int high_len;
        int low_len;
        int start_errors;
        bit ok;
        start_errors = errors;
        set_link(1'b1, 1'b1, 1'b1);
        for (i = 0; i < 3; i++)
        begin
            timer          = $unsigned($random(seed)) % 20;
            host.send_cmd  = 1'b0;   // timer only changes outside command mode
            host.ch2_timer = timer;
            repeat (3) step_cycle;
            host.send_cmd  = 1'b1;
            wait_level(SEL_SEND_2, 1'b1, 10, high_len, ok);
            for (k = 0; k < 2 && ok; k++)
            begin
                wait_level(SEL_SEND_2, 1'b0, 40, high_len, ok);
                if (ok)
                begin
                    check_equal(high_len, timer + 4,
                                $sformatf("cmd_send_2 high time, ch2_timer %0d", timer));
                    wait_level(SEL_SEND_2, 1'b1, 5, low_len, ok);
                end
                if (ok)
                begin
                    check_equal(low_len, 1, "cmd_send_2 low gap");
                end
            end
        end
        host.send_cmd = 1'b0;
        repeat (2) step_cycle;
        report_test("host_timed_channel", start_errors);
    endtask

    task run_follow_test;
        int   i;
        int   start_errors;
        logic prev;
        logic val;
        start_errors = errors;
        prev = 1'b0;
        check_equal(cmd_send_2, prev, "cmd_send_2 before follow test");
        for (i = 0; i < 10; i++)
        begin
            val          = ~prev;
            data_saved_2 = val;
            #1;
            check_equal(cmd_send_2, prev, "cmd_send_2 changed before the clock edge");
            step_cycle;
            check_equal(cmd_send_2, val, "cmd_send_2 one cycle after data_saved_2");
            prev = val;
        end
        report_test("data_saved_follow", start_errors);
    endtask

    task run_freeze_test;
        int   i;
        int   changes;
        int   start_errors;
        logic c1;
        logic c2;
        start_errors = errors;
        set_link(1'b0, 1'b1, 1'b1);   // mac not initialized
        host.send_cmd = 1'b1;
        data_saved_2  = 1'b1;
        c1 = cmd_send_1;
        c2 = cmd_send_2;
        changes = 0;
        for (i = 0; i < 300; i++)
        begin
            step_cycle;
            if (cmd_send_1 !== c1 || cmd_send_2 !== c2)
            begin
                changes++;
            end
        end
        check_equal(changes, 0, "command outputs changed with mac_inited low");
        report_test("link_not_ready_freeze", start_errors);
    endtask

    // ------------------------------
    // sequence
    // ------------------------------

    initial
    begin
        link         = '0;
        host         = '0;
        data_saved_2 = 1'b0;
        run_reset_test;
        run_blink_test;
        run_periodic_test;
        run_host_timed_test;
        run_follow_test;
        run_freeze_test;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
sfp_ctrl_pkg.sv
blink_divider.sv
periodic_send_channel.sv
host_send_channel.sv
send_control.sv
sfp_ctrl_top.sv
tb_clock_gen.sv
sfp_ctrl_tb.sv
